// File: hw/rf_32x264.sv
`timescale 1ns/1ps

// 32 by 264 two-port register file built from two 132-bit banks
// Both banks see the same address and strobes on each port
// Each bank stores one half of the word
module rf_32x264 (
    // Write port
     input  logic                wclk
    ,input  logic                we
    ,input  rf_pkg::rf_addr_t    waddr
    ,input  rf_pkg::rf_word_u    wdata

    // Read port, rst_n here is already synchronized to rclk
    ,input  logic                rclk
    ,input  logic                rst_n
    ,input  logic                re
    ,input  rf_pkg::rf_addr_t    raddr
    ,output rf_pkg::rf_word_u    rdata
);

    `include "rf_consts.svh"

    // Read data coming back from each bank before it is joined
    logic [`RF_BANK_W-1:0] bank_dout [`RF_BANKS];

    // ****************************************
    // Bank array
    // ****************************************

    // g_bank[0] holds the low half and g_bank[1] the high half
    for (genvar gi = 0; gi < `RF_BANKS; gi++) begin : g_bank
        rf_bank_32x132 u_bank (
             .wclk        (wclk)
            ,.we          (we)
            ,.waddr       (waddr)
            ,.wdata       (wdata.banks[gi])
            ,.rclk        (rclk)
            ,.rst_n       (rst_n)
            ,.re          (re)
            ,.raddr       (raddr)
            ,.data_out    (bank_dout[gi])
        );
    end

    // ****************************************
    // Read word assembly
    // ****************************************

    // Each bank output lands in its own half of the banks view
    // The flat view then carries the full word out of the module
    always_comb begin
        for (int i = 0; i < `RF_BANKS; i++) begin
            rdata.banks[i] = bank_dout[i];
        end
    end

endmodule

// File: hw/rf_bank_32x132.sv
`timescale 1ns/1ps

`include "rf_consts.svh"

// Behavioral model of one 32x132 two-port array
// It stands in for the hard macro and keeps its port behavior
// The write side works on wclk and the read side on rclk
// Only the read output register responds to the reset
module rf_bank_32x132 (
    // Write port
     input  logic                     wclk
    ,input  logic                     we
    ,input  rf_pkg::rf_addr_t         waddr
    ,input  logic [`RF_BANK_W-1:0]    wdata

    // Read port
    ,input  logic                     rclk
    ,input  logic                     rst_n
    ,input  logic                     re
    ,input  rf_pkg::rf_addr_t         raddr
    ,output logic [`RF_BANK_W-1:0]    data_out
);

    // ****************************************
    // Storage array
    // ****************************************

    // One entry per word
    // Contents survive a reset pulse just like the real macro
    logic [`RF_BANK_W-1:0] mem [`RF_DEPTH];

    // Write on the rising edge of wclk whenever the strobe is high
    // Every strobe lands in its own cycle since there is no back-pressure
    always_ff @(posedge wclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // ****************************************
    // Read output register
    // ****************************************

    // The read register loads the addressed word when re is high
    // Data is valid after the sampling edge, so latency is one cycle

    // The array is read before the write of the same edge takes effect,
    // so a collision on one address returns the old word
    // There is no bypass from the write data to the read output

    // With re low the register keeps its value, so data_out holds
    // the last word read even if that address is written later

    // While rst_n is low the output is forced to zero
    // A read issued during reset is dropped and does not load
    always_ff @(posedge rclk) begin
        if (!rst_n) begin
            data_out <= '0;
        end else if (re) begin
            data_out <= mem[raddr];
        end
    end

    // After reset data_out stays zero until the first read lands
    // That matches the cleared output latch of the hard macro

    // Every 5-bit address maps to one word of the 32-deep array

endmodule

// File: hw/rf_consts.svh
`ifndef RF_CONSTS_SVH
`define RF_CONSTS_SVH

// ****************************************
// Register file geometry
// ****************************************

// Number of words held in each bank, all banks share one address space
`define RF_DEPTH 32

// Address width, enough to reach every one of the RF_DEPTH words
`define RF_ADDR_W 5

// Data width of a single bank, matching the 132-bit hard macro
`define RF_BANK_W 132

// Banks placed side by side to form one full word
// The full word is RF_BANKS times RF_BANK_W bits wide
`define RF_BANKS 2

`endif

// File: hw/rf_pkg.sv
`include "rf_consts.svh"

package rf_pkg;

    // ****************************************
    // Addressing
    // ****************************************

    // One address into the register file, shared by the read and write ports
    typedef logic [`RF_ADDR_W-1:0] rf_addr_t;

    // ****************************************
    // Word layout
    // ****************************************

    // The same 264 bits are seen in two ways
    // The flat view is what the ports and the testbench handle
    // The banks view is how the wrapper splits the word over the macros
    // Index 0 of banks is the low half, bits 131 down to 0
    // Index 1 of banks is the high half, bits 263 down to 132
    typedef union packed {
        logic [`RF_BANKS*`RF_BANK_W-1:0]         flat;
        logic [`RF_BANKS-1:0][`RF_BANK_W-1:0]    banks;
    } rf_word_u;

endpackage

// File: hw/rf_reset_sync.sv
`timescale 1ns/1ps

// Brings the incoming reset into the read clock domain
// Assertion of the reset is seen at the first rclk edge that samples it low
// Release is delayed by the two flops so it lines up with rclk
module rf_reset_sync (
     input  logic    rclk
    ,input  logic    rst_n
    ,output logic    rst_n_sync
);

    // ****************************************
    // Synchronizer chain
    // ****************************************

    // Stage 0 takes the constant one, stage 1 drives the output
    logic [1:0] sync_q;

    always_ff @(posedge rclk) begin
        if (!rst_n) begin
            // Both stages drop together so the output goes low at once
            sync_q <= 2'b00;
        end else begin
            // A one walks in from the bottom after the reset is released
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // The last stage is the reset seen by the read side of the banks
    assign rst_n_sync = sync_q[1];

endmodule

// File: hw/rf_store_top.sv
`timescale 1ns/1ps

// Top level of the queue storage
// Ties the read side reset synchronizer to the 264-bit register file
module rf_store_top (
     input  logic                wclk
    ,input  logic                rclk
    ,input  logic                rst_n
    ,input  logic                we
    ,input  rf_pkg::rf_addr_t    waddr
    ,input  rf_pkg::rf_word_u    wdata
    ,input  logic                re
    ,input  rf_pkg::rf_addr_t    raddr
    ,output rf_pkg::rf_word_u    rdata
);

    // Reset for the bank output registers, released in step with rclk
    logic rst_n_sync;

    rf_reset_sync u_rst_sync (
         .rclk          (rclk)
        ,.rst_n         (rst_n)
        ,.rst_n_sync    (rst_n_sync)
    );

    // Write and read ports go straight through to the register file
    rf_32x264 u_rf (
         .wclk     (wclk)
        ,.we       (we)
        ,.waddr    (waddr)
        ,.wdata    (wdata)
        ,.rclk     (rclk)
        ,.rst_n    (rst_n_sync)
        ,.re       (re)
        ,.raddr    (raddr)
        ,.rdata    (rdata)
    );

endmodule

// File: project.f
+incdir+hw
hw/rf_pkg.sv
hw/rf_reset_sync.sv
hw/rf_bank_32x132.sv
hw/rf_32x264.sv
hw/rf_store_top.sv
verification/rf_store_chk.sv
verification/rf_store_tb.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f project.f \
    --top-module rf_store_tb \
    -o rf_store_sim

output=$(./obj_dir/rf_store_sim +verilator+error+limit+1000 2>&1) || true
printf '%s\n' "$output"

printf '%s\n' "$output" | grep -qx "All checks passed"

// File: verification/rf_store_cases.txt
// Columns: op, address, write data, expected rdata (hex, words of 264 bits)
// Ops: 0 idle, 1 write, 2 read, 3 read with expect, 4 read and write, 5 reset, f end
// Idle cycles after reset, rdata stays zero
0 00 0 0
0 1f 0 0
// Halves that differ and a walking one across bits 131 and 132
1 00 fffffffffffffffffffffffffffffffff000000000000000000000000000000000 0
1 1f fffffffffffffffffffffffffffffffff 0
1 05 800000000000000000000000000000000 0
1 06 1000000000000000000000000000000000 0
1 0a 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef01 0
3 00 0 fffffffffffffffffffffffffffffffff000000000000000000000000000000000
3 1f 0 fffffffffffffffffffffffffffffffff
3 05 0 800000000000000000000000000000000
3 06 0 1000000000000000000000000000000000
3 0a 0 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef01
// Hold while the read address is written again
1 15 deadbeefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeef01 0
3 15 0 deadbeefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeef01
1 15 c0ffee00c0ffee00c0ffee00c0ffee00c0ffee00c0ffee00c0ffee00c0ffee0011 0
0 15 abc 0
0 15 0 0
3 15 0 c0ffee00c0ffee00c0ffee00c0ffee00c0ffee00c0ffee00c0ffee00c0ffee0011
// Read and write on one address return the old word first
4 15 0badf00d0badf00d0badf00d0badf00d0badf00d0badf00d0badf00d0badf00d22 c0ffee00c0ffee00c0ffee00c0ffee00c0ffee00c0ffee00c0ffee00c0ffee0011
3 15 0 0badf00d0badf00d0badf00d0badf00d0badf00d0badf00d0badf00d0badf00d22
// Data on the bus without we leaves the word alone
0 0a 1234 0
3 0a 0 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef01
1 10 13579bdf13579bdf13579bdf13579bdf13579bdf13579bdf13579bdf13579bdf33 0
1 03 2468ace02468ace02468ace02468ace02468ace02468ace02468ace02468ace044 0
2 10 0 0
3 03 0 2468ace02468ace02468ace02468ace02468ace02468ace02468ace02468ace044
4 03 fedcba98fedcba98fedcba98fedcba98fedcba98fedcba98fedcba98fedcba9855 2468ace02468ace02468ace02468ace02468ace02468ace02468ace02468ace044
3 03 0 fedcba98fedcba98fedcba98fedcba98fedcba98fedcba98fedcba98fedcba9855
// Reset pulse with a read of address 0 inside it
5 00 0 0
0 00 0 0
// Stored words survive the pulse
3 00 0 fffffffffffffffffffffffffffffffff000000000000000000000000000000000
3 1f 0 fffffffffffffffffffffffffffffffff
3 05 0 800000000000000000000000000000000
3 06 0 1000000000000000000000000000000000
3 15 0 0badf00d0badf00d0badf00d0badf00d0badf00d0badf00d0badf00d0badf00d22
3 10 0 13579bdf13579bdf13579bdf13579bdf13579bdf13579bdf13579bdf13579bdf33
3 03 0 fedcba98fedcba98fedcba98fedcba98fedcba98fedcba98fedcba98fedcba9855
f 00 0 0

// File: verification/rf_store_chk.sv
`timescale 1ns/1ps

// Concurrent checks on the read port and the output reset
module rf_store_chk (
     input  logic                wclk
    ,input  logic                rclk
    ,input  logic                rst_n_sync
    ,input  logic                we
    ,input  rf_pkg::rf_addr_t    waddr
    ,input  logic                re
    ,input  rf_pkg::rf_addr_t    raddr
    ,input  rf_pkg::rf_word_u    rdata
);

    import rf_pkg::*;

    localparam rf_word_u ZERO_WORD = '0;

    // Running count of assertion failures
    int unsigned fail_count = 0;

    // ****************************************
    // Read port
    // ****************************************

    // The output register is cleared at every edge of the read reset
    a_reset_clears: assert property (@(posedge rclk)
        !rst_n_sync |=> (rdata.flat == ZERO_WORD.flat))
        else begin
            fail_count++;
            $error("rdata is not zero after an edge with the read reset active");
        end

    // Without a read the output keeps the last word
    a_hold: assert property (@(posedge rclk) (rst_n_sync && !re) |=> $stable(rdata.flat))
        else begin
            fail_count++;
            $error("rdata changed after an edge without a read");
        end

    // Addresses are known whenever a strobe uses them
    a_waddr_known: assert property (@(posedge wclk) we |-> !$isunknown(waddr))
        else begin
            fail_count++;
            $error("waddr has unknown bits during a write");
        end

    a_raddr_known: assert property (@(posedge rclk) re |-> !$isunknown(raddr))
        else begin
            fail_count++;
            $error("raddr has unknown bits during a read");
        end

endmodule

bind rf_store_top rf_store_chk chk0 (
     .wclk          (wclk)
    ,.rclk          (rclk)
    ,.rst_n_sync    (rst_n_sync)
    ,.we            (we)
    ,.waddr         (waddr)
    ,.re            (re)
    ,.raddr         (raddr)
    ,.rdata         (rdata)
);

// File: verification/rf_store_tb.sv
`timescale 1ns/1ps

// Testbench for the 264-bit queue storage register file
// One clock drives both the write and the read side of the DUT
module rf_store_tb;

    `include "rf_consts.svh"
    import rf_pkg::*;

    // ****************************************
    // Timing and case encoding
    // ****************************************

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_CASES    = 64;
    // Each case takes four words in the file for op, address, data and expected word
    localparam int FIELDS       = 4;

    localparam logic [3:0] OP_WRITE    = 4'h1;
    localparam logic [3:0] OP_READ     = 4'h2;
    localparam logic [3:0] OP_READ_EXP = 4'h3;
    localparam logic [3:0] OP_RW_SAME  = 4'h4;
    localparam logic [3:0] OP_RESET    = 4'h5;
    localparam logic [3:0] OP_END      = 4'hf;

    logic        clk;
    logic        rst_n;
    logic        we;
    logic        re;
    rf_addr_t    waddr;
    rf_addr_t    raddr;
    rf_word_u    wdata;
    rf_word_u    rdata;

    logic [`RF_BANKS*`RF_BANK_W-1:0] case_mem [MAX_CASES*FIELDS];

    // Reference state holding the stored words and the word rdata should show
    rf_word_u    model_mem [`RF_DEPTH];
    rf_word_u    model_rdata;

    int          n_cases;
    int          mismatch_count;
    int          timeout_count;
    bit          cases_ready;

    rf_store_top dut0 (
         .wclk     (clk)
        ,.rclk     (clk)
        ,.rst_n    (rst_n)
        ,.we       (we)
        ,.waddr    (waddr)
        ,.wdata    (wdata)
        ,.re       (re)
        ,.raddr    (raddr)
        ,.rdata    (rdata)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // ****************************************
    // Helpers
    // ****************************************

    task automatic check_word(input int idx, input rf_word_u exp_word, input rf_word_u act_word);
        if (act_word !== exp_word) begin
            $display("Fail rdata case %0d expected %h actual %h", idx, exp_word.flat,
                     act_word.flat);
            mismatch_count++;
        end
    endtask

    // The file ends with an end marker and every entry before it is a case
    function automatic int count_cases();
        int n;
        n = 0;
        while (n < MAX_CASES && case_mem[n*FIELDS][3:0] != OP_END) begin
            n++;
        end
        return n;
    endfunction

    function automatic int total_errors();
        return mismatch_count + timeout_count + int'(dut0.chk0.fail_count);
    endfunction

    task automatic report_counts();
        $display("Errors: %0d mismatches, %0d assertion failures, %0d timeouts",
                 mismatch_count, dut0.chk0.fail_count, timeout_count);
    endtask

    // Power-on reset with rdata checked for zero once the banks are cleared
    task automatic hold_reset();
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge clk);
            if (c >= 2) begin
                check_word(-1, model_rdata, rdata);
            end
        end
        @(posedge clk);
        rst_n <= 1'b1;
        // Release needs two synchronizer stages and one edge at the banks
        repeat (3) @(posedge clk);
    endtask

    // Mid-run reset with a read issued while the output reset is active
    task automatic pulse_reset(input int idx, input rf_addr_t addr);
        @(posedge clk);
        rst_n <= 1'b0;
        @(posedge clk);
        re    <= 1'b1;
        raddr <= addr;
        repeat (2) @(posedge clk);
        model_rdata = '0;
        @(negedge clk);
        check_word(idx, model_rdata, rdata);
        @(posedge clk);
        rst_n <= 1'b1;
        re    <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_word(idx, model_rdata, rdata);
    endtask

    task automatic run_case(input int idx);
        logic [3:0] op;
        rf_addr_t   addr;
        rf_word_u   data;
        rf_word_u   exp_word;
        logic       do_write;
        logic       do_read;
        op            = case_mem[idx*FIELDS][3:0];
        addr          = case_mem[idx*FIELDS+1][`RF_ADDR_W-1:0];
        data.flat     = case_mem[idx*FIELDS+2];
        exp_word.flat = case_mem[idx*FIELDS+3];
        do_write      = (op == OP_WRITE) || (op == OP_RW_SAME);
        do_read       = (op == OP_READ) || (op == OP_READ_EXP) || (op == OP_RW_SAME);
        if (op == OP_RESET) begin
            pulse_reset(idx, addr);
        end else begin
            @(posedge clk);
            we    <= do_write;
            re    <= do_read;
            waddr <= addr;
            raddr <= addr;
            wdata <= data;
            // Not sampled yet, so rdata still shows the previous word
            @(negedge clk);
            check_word(idx, model_rdata, rdata);
            @(posedge clk);
            we <= 1'b0;
            re <= 1'b0;
            // The read sees the array before the write of the same edge
            if (do_read) begin
                model_rdata = model_mem[addr];
            end
            if (do_write) begin
                model_mem[addr] = data;
            end
            @(negedge clk);
            check_word(idx, model_rdata, rdata);
            if (op == OP_READ_EXP || op == OP_RW_SAME) begin
                check_word(idx, exp_word, rdata);
            end
        end
    endtask

    // ****************************************
    // Stimulus and verdict
    // ****************************************

    initial begin : main
        clk            = 1'b0;
        rst_n          = 1'b0;
        we             = 1'b0;
        re             = 1'b0;
        waddr          = '0;
        raddr          = '0;
        wdata          = '0;
        model_rdata    = '0;
        mismatch_count = 0;
        timeout_count  = 0;
        $readmemh("verification/rf_store_cases.txt", case_mem);
        n_cases     = count_cases();
        cases_ready = 1'b1;
        hold_reset();
        for (int i = 0; i < n_cases; i++) begin
            run_case(i);
        end
        // One more edge so the assertions see the last cycle
        @(posedge clk);
        report_counts();
        if (total_errors() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Budget of four cycles per case plus a margin for the power-on reset
    initial begin : watchdog
        longint limit_ns;
        wait (cases_ready);
        limit_ns = (longint'(n_cases) * 4 + 20) * CLK_PERIOD;
        #(limit_ns);
        timeout_count++;
        $display("Run timed out after %0d ns before all cases finished", limit_ns);
        report_counts();
        $display("Checks failed");
        $finish;
    end

endmodule
